// File: verilog/vmask_settings.svh
`ifndef VMASK_SETTINGS_SVH
`define VMASK_SETTINGS_SVH

// Vector register length in bits
// The design also works with 256 or 512, as long as it stays a multiple of 64
`define VMASK_VLEN 128

// Width of the scalar result written back to the integer register file
// The vpopc count and the vfirst index are zero-extended to this width
`define VMASK_XLEN 64

// With SEW fixed at 8 bits the mask holds VLEN/8 elements, the largest count
// that either reduction has to handle

`endif

// File: verilog/vmask_pkg.sv
`include "vmask_settings.svh"
`default_nettype none

package vmask_pkg;

    localparam int VLEN = `VMASK_VLEN;
    localparam int XLEN = `VMASK_XLEN;

    // One mask bit per element, and the smallest element is a byte
    localparam int MASK_W = VLEN / 8;

    // Wide enough to hold any count from zero up to MASK_W
    localparam int CNT_W = $clog2(MASK_W + 1);

    typedef enum logic [1:0] {
        SEW_8  = 2'b00,
        SEW_16 = 2'b01,
        SEW_32 = 2'b10,
        SEW_64 = 2'b11
    } sew_t;

    typedef enum logic {
        OP_VPOPC  = 1'b0,
        OP_VFIRST = 1'b1
    } vmask_op_t;

    typedef logic [VLEN-1:0]   bus_simd_t;
    typedef logic [MASK_W-1:0] bus_mask_t;
    typedef logic [XLEN-1:0]   bus64_t;

    typedef struct packed {
        vmask_op_t op;
        sew_t      sew;
        bus_simd_t vs2;
        bus_mask_t vm;
        logic      use_mask;
        logic [4:0] rd;
    } vmask_req_t;

    typedef struct packed {
        logic [4:0] rd;
        bus64_t     data;
    } vmask_resp_t;

    // Number of elements held by one vector register at the given width
    function automatic logic [CNT_W-1:0] elem_count(input sew_t sew);
        logic [CNT_W-1:0] cnt;
        case (sew)
            SEW_8:   cnt = CNT_W'(VLEN / 8);
            SEW_16:  cnt = CNT_W'(VLEN / 16);
            SEW_32:  cnt = CNT_W'(VLEN / 32);
            SEW_64:  cnt = CNT_W'(VLEN / 64);
            default: cnt = '0;
        endcase
        return cnt;
    endfunction

    // Element i is active when bit i of vs2 is set, it lies below the element
    // count, and the mask bit allows it whenever masking is on
    function automatic bus_mask_t active_bits(
        input sew_t      sew,
        input bus_simd_t vs2,
        input bus_mask_t vm,
        input logic      use_mask
    );
        bus_mask_t        act;
        logic [CNT_W-1:0] cnt;
        cnt = elem_count(sew);
        for (int i = 0; i < MASK_W; i++) begin
            act[i] = vs2[i] & (vm[i] | ~use_mask) & (i < int'(cnt));
        end
        return act;
    endfunction

endpackage

`default_nettype wire

// File: verilog/vpopc.sv
`timescale 1ns/1ps
`default_nettype none

module vpopc (
    input  vmask_pkg::sew_t      sew_i,
    input  vmask_pkg::bus_simd_t data_vs2_i,
    input  vmask_pkg::bus_mask_t data_vm_i,
    input  logic                 use_mask_i,
    output vmask_pkg::bus64_t    data_vd_o
);

    import vmask_pkg::*;

    bus_mask_t        active;
    logic [CNT_W-1:0] count;

    // Elements past VLEN/SEW are cleared here, so the adder below can simply
    // run over the full mask width for every SEW
    always_comb begin
        active = active_bits(sew_i, data_vs2_i, data_vm_i, use_mask_i);
    end

    // Population count of the active elements
    // The largest possible value is MASK_W, which CNT_W bits always cover
    always_comb begin
        count = '0;
        for (int i = 0; i < MASK_W; i++) begin
            count = count + CNT_W'(active[i]);
        end
    end

    // vcpop.m writes an unsigned count, so the upper bits are zero
    assign data_vd_o = {{(XLEN - CNT_W){1'b0}}, count};

endmodule

`default_nettype wire

// File: verilog/vfirst.sv
`timescale 1ns/1ps
`default_nettype none

module vfirst (
    input  vmask_pkg::sew_t      sew_i,
    input  vmask_pkg::bus_simd_t data_vs2_i,
    input  vmask_pkg::bus_mask_t data_vm_i,
    input  logic                 use_mask_i,
    output vmask_pkg::bus64_t    data_vd_o
);

    import vmask_pkg::*;

    bus_mask_t        active;
    logic             found;
    logic [CNT_W-1:0] index;

    // Same active-element vector as vcpop.m uses
    always_comb begin
        active = active_bits(sew_i, data_vs2_i, data_vm_i, use_mask_i);
    end

    // Priority scan from element 0 upward
    // Once a set bit has been seen the later ones are ignored
    always_comb begin
        found = 1'b0;
        index = '0;
        for (int i = 0; i < MASK_W; i++) begin
            if (active[i] && !found) begin
                found = 1'b1;
                index = CNT_W'(i);
            end
        end
    end

    // No active element returns -1, which is all ones in the scalar register
    always_comb begin
        if (found) begin
            data_vd_o = {{(XLEN - CNT_W){1'b0}}, index};
        end else begin
            data_vd_o = '1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/vmask_result.sv
`timescale 1ns/1ps
`default_nettype none

module vmask_result (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   valid_i,
    input  vmask_pkg::vmask_op_t   op_i,
    input  logic [4:0]             rd_i,
    input  vmask_pkg::bus64_t      popc_i,
    input  vmask_pkg::bus64_t      first_i,
    output logic                   valid_o,
    output vmask_pkg::vmask_resp_t resp_o
);

    import vmask_pkg::*;

    bus64_t      sel_data;
    vmask_resp_t resp_d;
    vmask_resp_t resp_q;
    logic        valid_q;

    // Both reductions are computed every cycle, the opcode picks the one
    // that is written back
    always_comb begin
        case (op_i)
            OP_VPOPC:  sel_data = popc_i;
            OP_VFIRST: sel_data = first_i;
            default:   sel_data = popc_i;
        endcase
    end

    always_comb begin
        resp_d.rd   = rd_i;
        resp_d.data = sel_data;
    end

    // Valid follows the input strobe one cycle later
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    // The response only loads on a valid request, so it keeps its last value
    // through idle cycles
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            resp_q <= '0;
        end else if (valid_i) begin
            resp_q <= resp_d;
        end
    end

    assign valid_o = valid_q;
    assign resp_o  = resp_q;

endmodule

`default_nettype wire

// File: verilog/vmask_unit.sv
`timescale 1ns/1ps
`default_nettype none

module vmask_unit (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   valid_i,
    input  vmask_pkg::vmask_req_t  req_i,
    output logic                   valid_o,
    output vmask_pkg::vmask_resp_t resp_o
);

    import vmask_pkg::*;

    bus64_t popc_data;
    bus64_t first_data;

    // vcpop.m datapath
    vpopc popc0 (
        .sew_i      (req_i.sew),
        .data_vs2_i (req_i.vs2),
        .data_vm_i  (req_i.vm),
        .use_mask_i (req_i.use_mask),
        .data_vd_o  (popc_data)
    );

    // vfirst.m datapath, fed from the same operands
    vfirst first0 (
        .sew_i      (req_i.sew),
        .data_vs2_i (req_i.vs2),
        .data_vm_i  (req_i.vm),
        .use_mask_i (req_i.use_mask),
        .data_vd_o  (first_data)
    );

    // Single register stage that gives the unit its one-cycle latency
    vmask_result result0 (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .valid_i (valid_i),
        .op_i    (req_i.op),
        .rd_i    (req_i.rd),
        .popc_i  (popc_data),
        .first_i (first_data),
        .valid_o (valid_o),
        .resp_o  (resp_o)
    );

endmodule

`default_nettype wire

// File: bench/vmask_unit_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module vmask_unit_asserts (
    input logic                   clk_i,
    input logic                   reset_i,
    input logic                   valid_i,
    input vmask_pkg::vmask_req_t  req_i,
    input logic                   valid_o,
    input vmask_pkg::vmask_resp_t resp_o
);

    import vmask_pkg::*;

    function automatic bus64_t elem_limit(input sew_t sew);
        case (sew)
            SEW_8:   return bus64_t'(VLEN / 8);
            SEW_16:  return bus64_t'(VLEN / 16);
            SEW_32:  return bus64_t'(VLEN / 32);
            default: return bus64_t'(VLEN / 64);
        endcase
    endfunction

    reset_clears_valid: assert property (@(posedge clk_i) reset_i |=> !valid_o)
        else $error("valid_o is high in the cycle after reset");

    // One-cycle latency, no matter what the request holds
    valid_follows_input: assert property (@(posedge clk_i) disable iff (reset_i)
        !$past(reset_i) |-> valid_o == $past(valid_i))
        else $error("valid_o does not follow valid_i by one cycle");

    first_in_range: assert property (@(posedge clk_i) disable iff (reset_i)
        (valid_o && $past(req_i.op) == OP_VFIRST)
            |-> (resp_o.data == '1 || resp_o.data < elem_limit($past(req_i.sew))))
        else $error("vfirst result is neither all ones nor below the element count");

    popc_in_range: assert property (@(posedge clk_i) disable iff (reset_i)
        (valid_o && $past(req_i.op) == OP_VPOPC)
            |-> resp_o.data <= elem_limit($past(req_i.sew)))
        else $error("vpopc result exceeds the element count");

endmodule

bind vmask_unit vmask_unit_asserts asrt0 (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (valid_i),
    .req_i   (req_i),
    .valid_o (valid_o),
    .resp_o  (resp_o)
);

`default_nettype wire

// File: bench/tb_vmask_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "vmask_settings.svh"

module tb_vmask_unit;

    import vmask_pkg::*;

    localparam int TB_VLEN      = `VMASK_VLEN;
    localparam int TB_MASK      = TB_VLEN / 8;
    localparam int RESULT_LIMIT = 4;
    localparam int DRAIN_LIMIT  = 8;
    localparam int STREAM_LEN   = 300;

    logic        clk_i;
    logic        reset_i;
    logic        valid_i;
    vmask_req_t  req_i;
    logic        valid_o;
    vmask_resp_t resp_o;

    logic [31:0] lfsr_state;
    vmask_resp_t last_resp;

    // One entry per driven cycle, checked on the following cycle
    logic        exp_valid_q[$];
    vmask_resp_t exp_resp_q[$];

    vmask_unit dut0 (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .valid_i (valid_i),
        .req_i   (req_i),
        .valid_o (valid_o),
        .resp_o  (resp_o)
    );

    always #5 clk_i = ~clk_i;

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [TB_VLEN-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v[i] = lfsr_state[0];
        end
    endtask

    task automatic random_req(output vmask_req_t r);
        logic [TB_VLEN-1:0] bits;
        draw_bits(1, bits);
        r.op = vmask_op_t'(bits[0]);
        draw_bits(2, bits);
        r.sew = sew_t'(bits[1:0]);
        draw_bits(TB_VLEN, bits);
        r.vs2 = bits;
        draw_bits(TB_MASK, bits);
        r.vm = bits[TB_MASK-1:0];
        draw_bits(1, bits);
        r.use_mask = bits[0];
        draw_bits(5, bits);
        r.rd = bits[4:0];
    endtask

    function automatic int elems_of(input sew_t sew);
        case (sew)
            SEW_8:   return TB_VLEN / 8;
            SEW_16:  return TB_VLEN / 16;
            SEW_32:  return TB_VLEN / 32;
            default: return TB_VLEN / 64;
        endcase
    endfunction

    // Reference model that walks the elements below VLEN/SEW one at a time
    function automatic vmask_resp_t model_resp(input vmask_req_t r);
        vmask_resp_t want;
        int          n;
        int          ones;
        int          first_idx;
        logic        bit_on;
        n = elems_of(r.sew);
        ones = 0;
        first_idx = -1;
        for (int i = 0; i < n; i++) begin
            bit_on = r.vs2[i];
            if (r.use_mask && !r.vm[i]) begin
                bit_on = 1'b0;
            end
            if (bit_on) begin
                ones++;
                if (first_idx < 0) begin
                    first_idx = i;
                end
            end
        end
        want.rd = r.rd;
        if (r.op == OP_VPOPC) begin
            want.data = bus64_t'(ones);
        end else if (first_idx < 0) begin
            want.data = '1;
        end else begin
            want.data = bus64_t'(first_idx);
        end
        return want;
    endfunction

    task automatic check_value(input string name, input bus64_t got, input bus64_t want);
        if (got !== want) begin
            $display("Fail %s: got %h, expected %h", name, got, want);
            $display("FAIL: see errors above");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out while waiting for %s", what);
        $display("FAIL: see errors above");
        $fatal(1, "Stopped on a timeout");
    endtask

    task automatic check_pending();
        logic        want_valid;
        vmask_resp_t want;
        if (exp_valid_q.size() > 0) begin
            want_valid = exp_valid_q.pop_front();
            want = exp_resp_q.pop_front();
            check_value("valid_o", bus64_t'(valid_o), bus64_t'(want_valid));
            check_value("resp_o.rd", bus64_t'(resp_o.rd), bus64_t'(want.rd));
            check_value("resp_o.data", resp_o.data, want.data);
        end
    endtask

    // Check last cycle's outcome, then drive this cycle's inputs
    task automatic tick(input logic v, input vmask_req_t r);
        @(posedge clk_i);
        #1;
        check_pending();
        valid_i = v;
        req_i = r;
        if (v) begin
            last_resp = model_resp(r);
        end
        exp_valid_q.push_back(v);
        exp_resp_q.push_back(last_resp);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_valid_q.size() > 0) begin
            if (waited >= DRAIN_LIMIT) begin
                report_timeout("the outstanding responses");
            end
            @(posedge clk_i);
            #1;
            check_pending();
            valid_i = 1'b0;
            waited++;
        end
    endtask

    // Send one request alone and wait for valid_o, which must come after one cycle
    task automatic run_single(input vmask_req_t r);
        int          cycles;
        vmask_resp_t want;
        want = model_resp(r);
        @(posedge clk_i);
        #1;
        valid_i = 1'b1;
        req_i = r;
        @(posedge clk_i);
        #1;
        valid_i = 1'b0;
        cycles = 1;
        while (!valid_o) begin
            if (cycles >= RESULT_LIMIT) begin
                report_timeout("valid_o after a single request");
            end
            @(posedge clk_i);
            #1;
            cycles++;
        end
        check_value("valid_o latency", bus64_t'(cycles), bus64_t'(1));
        check_value("resp_o.rd", bus64_t'(resp_o.rd), bus64_t'(want.rd));
        check_value("resp_o.data", resp_o.data, want.data);
        last_resp = want;
    endtask

    initial begin
        vmask_req_t         r;
        logic [TB_VLEN-1:0] bits;
        int                 n;
        clk_i = 1'b0;
        reset_i = 1'b1;
        valid_i = 1'b0;
        req_i = '0;
        lfsr_state = 32'ha860;
        last_resp = '0;

        repeat (3) @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        // Reset state before any request
        for (int k = 0; k < 2; k++) begin
            check_value("valid_o", bus64_t'(valid_o), '0);
            check_value("resp_o.rd", bus64_t'(resp_o.rd), '0);
            check_value("resp_o.data", resp_o.data, '0);
            @(posedge clk_i);
            #1;
        end

        // Unmasked vcpop.m at every SEW
        for (int s = 0; s < 4; s++) begin
            for (int k = 0; k < 6; k++) begin
                random_req(r);
                r.op = OP_VPOPC;
                r.sew = sew_t'(s);
                r.use_mask = 1'b0;
                tick(1'b1, r);
            end
        end
        drain();

        // Masked requests of both kinds where every odd one also sets the bits
        // above the element count
        for (int k = 0; k < 48; k++) begin
            random_req(r);
            r.use_mask = 1'b1;
            if (k % 2 == 1) begin
                n = elems_of(r.sew);
                for (int i = n; i < TB_VLEN; i++) begin
                    r.vs2[i] = 1'b1;
                end
                for (int i = n; i < TB_MASK; i++) begin
                    r.vm[i] = 1'b1;
                end
            end
            tick(1'b1, r);
        end
        drain();

        // vfirst.m corners
        for (int s = 0; s < 4; s++) begin
            n = elems_of(sew_t'(s));
            r = '0;
            r.op = OP_VFIRST;
            r.sew = sew_t'(s);
            r.rd = 5'(s + 1);
            run_single(r);
            bits = '1;
            r.vs2 = bits << (n - 1);
            run_single(r);
            r.vs2 = '0;
            r.vs2[0] = 1'b1;
            run_single(r);
            r.vs2 = '1;
            r.vm = '0;
            r.use_mask = 1'b1;
            run_single(r);
        end

        // Streaming with random idle gaps
        for (int k = 0; k < STREAM_LEN; k++) begin
            random_req(r);
            draw_bits(2, bits);
            tick(bits[1:0] != 2'b00, r);
        end
        drain();

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+verilog
verilog/vmask_pkg.sv
verilog/vpopc.sv
verilog/vfirst.sv
verilog/vmask_result.sv
verilog/vmask_unit.sv
bench/vmask_unit_asserts.sv
bench/tb_vmask_unit.sv

// File: Makefile
# Verilator build and run for the mask-reduction unit

VERILATOR ?= verilator
TOP       ?= tb_vmask_unit
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j $(JOBS)
PASS_MSG  ?= PASS: all tests

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard verilog/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source, a header or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only if the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
